// File: Bender.yml
package:
  name: memsys

sources:
  - include_dirs:
      - src
    files:
      - src/memsysPkg.sv
      - src/entryArray.sv
      - src/wayLookup.sv
      - src/bankedMemory.sv
      - src/cacheController.sv
      - src/memSystem.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/memSystemTb.sv

// File: bench/memSystemRef.svh
`ifndef MEMSYSTEMREF_SVH
`define MEMSYSTEMREF_SVH

// shadow of main memory, keyed by word address
// words never written read back as zero
wordT shadowMem [int];

// expected read word at a byte address
function automatic wordT expectedRead(input addrT addr);
   int wordAddr;
   wordAddr = int'(addr >> 1);
   if (shadowMem.exists(wordAddr)) begin
      return shadowMem[wordAddr];
   end
   return '0;
endfunction

// a write updates the shadow right away
function automatic void shadowWrite(input addrT addr, input wordT data);
   shadowMem[int'(addr >> 1)] = data;
endfunction

// xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// compare one value, stop at the first mismatch
task automatic checkEq(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
   if (expected !== actual) begin
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      stopOnError();
   end
endtask

`endif

// File: bench/memSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSystemTb;
   import memsysPkg::*;

   localparam int readyLimit = 50;
   localparam int respLimit = 500;

   logic clk;
   logic rstN;
   logic reqValid;
   logic reqReady;
   logic reqWrite;
   addrT reqAddr;
   wordT reqData;
   logic respValid;
   logic respReady;
   wordT respData;
   logic respHit;

   // expected responses in issue order
   logic expIsRead [$];
   wordT expData [$];
   logic expHitChk [$];
   logic expHitVal [$];

   logic [31:0] rngState;
   logic gapMode;
   int reqCount;
   int respCount;

   // checker state
   logic heldPrev;
   wordT prevData;
   logic prevHit;
   logic busy;

   `include "memSystemRef.svh"

   memSystem dut0 (
      .clk      (clk),
      .rstN     (rstN),
      .reqValid (reqValid),
      .reqReady (reqReady),
      .reqWrite (reqWrite),
      .reqAddr  (reqAddr),
      .reqData  (reqData),
      .respValid(respValid),
      .respReady(respReady),
      .respData (respData),
      .respHit  (respHit)
   );

   // 8 ns clock
   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic stopOnError();
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [31:0] nextRandom();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   // ########################################
   // request and response driving
   // ########################################
   // waits for the response transfer and drives respReady gaps meanwhile
   task automatic waitResponse();
      int cycles;
      bit done;
      logic [31:0] r;
      cycles = 0;
      done = 0;
      while (!done) begin
         @(posedge clk);
         done = respValid && respReady;
         cycles++;
         if (!done && cycles > respLimit) begin
            $display("timeout waiting for respValid at %0t ns", $time);
            stopOnError();
         end
         r = nextRandom();
         // about one cycle in four held off in gap mode
         respReady <= gapMode ? (r[1:0] != 2'b00) : 1'b1;
      end
   endtask

   task automatic issueRequest(input logic write, input addrT addr, input wordT data,
                               input logic hitChk, input logic expHit);
      int cycles;
      bit accepted;
      expIsRead.push_back(!write);
      expData.push_back(expectedRead(addr));
      expHitChk.push_back(hitChk);
      expHitVal.push_back(expHit);
      if (write) begin
         shadowWrite(addr, data);
      end
      reqCount++;
      reqValid <= 1'b1;
      reqWrite <= write;
      reqAddr <= addr;
      reqData <= data;
      cycles = 0;
      accepted = 0;
      while (!accepted) begin
         @(posedge clk);
         accepted = reqReady;
         cycles++;
         if (!accepted && cycles > readyLimit) begin
            $display("timeout waiting for reqReady at %0t ns", $time);
            stopOnError();
         end
      end
      reqValid <= 1'b0;
      waitResponse();
   endtask

   function automatic addrT makeAddr(input tagT tag, input indexT idx, input logic [1:0] word);
      return addrT'({tag, idx, word, 1'b0});
   endfunction

   // one random access over four indexes and eight tags
   task automatic randomAccess();
      logic [31:0] r;
      addrT addr;
      r = nextRandom();
      addr = makeAddr(tagT'(r[12:10]), indexT'(8'h80 + r[9:8]), r[14:13]);
      issueRequest(r[15], addr, r[31:16], 1'b0, 1'b0);
   endtask

   // ########################################
   // response checker
   // ########################################
   always @(posedge clk) begin
      if (rstN) begin
         // a held response must not move
         if (heldPrev) begin
            checkEq("respValid", 1, respValid);
            checkEq("respData", prevData, respData);
            checkEq("respHit", prevHit, respHit);
         end
         // no new request while one is in flight
         if (busy) begin
            checkEq("reqReady", 0, reqReady);
         end
         if (reqValid && reqReady) begin
            busy = 1'b1;
         end
         if (respValid && respReady) begin
            respCount++;
            busy = 1'b0;
            if (expIsRead.size() == 0) begin
               $display("response at %0t ns with no request pending", $time);
               stopOnError();
            end
            if (expIsRead.pop_front()) begin
               checkEq("respData", expData[0], respData);
            end
            if (expHitChk.pop_front()) begin
               checkEq("respHit", expHitVal[0], respHit);
            end
            void'(expData.pop_front());
            void'(expHitVal.pop_front());
         end
         heldPrev = respValid && !respReady;
         prevData = respData;
         prevHit = respHit;
      end
   end

   // ########################################
   // scenario sequence
   // ########################################
   initial begin
      rngState = 32'h2ba5;
      gapMode = 1'b0;
      reqCount = 0;
      respCount = 0;
      heldPrev = 1'b0;
      busy = 1'b0;
      rstN <= 1'b0;
      reqValid <= 1'b0;
      reqWrite <= 1'b0;
      reqAddr <= '0;
      reqData <= '0;
      respReady <= 1'b1;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      @(posedge clk);

      // idle after reset and then a cold read
      checkEq("reqReady", 1, reqReady);
      checkEq("respValid", 0, respValid);
      issueRequest(1'b0, makeAddr(5'd1, 8'h04, 2'd0), '0, 1'b1, 1'b0);

      // write allocates, so the read back hits
      issueRequest(1'b1, makeAddr(5'd2, 8'h05, 2'd2), 16'hbeef, 1'b0, 1'b0);
      issueRequest(1'b0, makeAddr(5'd2, 8'h05, 2'd2), '0, 1'b1, 1'b1);

      // three tags on one index push a dirty line out to memory
      issueRequest(1'b1, makeAddr(5'd3, 8'h21, 2'd1), 16'h1111, 1'b0, 1'b0);
      issueRequest(1'b1, makeAddr(5'd9, 8'h21, 2'd1), 16'h2222, 1'b0, 1'b0);
      issueRequest(1'b1, makeAddr(5'd17, 8'h21, 2'd1), 16'h3333, 1'b0, 1'b0);
      issueRequest(1'b0, makeAddr(5'd3, 8'h21, 2'd1), '0, 1'b0, 1'b0);
      issueRequest(1'b0, makeAddr(5'd9, 8'h21, 2'd1), '0, 1'b0, 1'b0);
      issueRequest(1'b0, makeAddr(5'd17, 8'h21, 2'd1), '0, 1'b0, 1'b0);

      // random mix without a hit flag check
      for (int i = 0; i < 300; i++) begin
         randomAccess();
      end

      // same traffic with respReady gaps
      gapMode = 1'b1;
      for (int i = 0; i < 60; i++) begin
         randomAccess();
      end
      gapMode = 1'b0;
      respReady <= 1'b1;

      repeat (2) @(posedge clk);
      checkEq("response count", reqCount, respCount);
      checkEq("pending responses", 0, expIsRead.size());

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/bankedMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "memsys_consts.svh"

// four bank main memory, a simulation model
module bankedMemory (
   input  logic             clk,
   input  logic             rstN,
   input  logic             memValid,
   input  logic             memWrite,
   input  memsysPkg::addrT  memAddr,
   input  memsysPkg::wordT  memWrData,
   output logic             memReady,
   output logic             memRdValid,
   output memsysPkg::wordT  memRdData
);
   import memsysPkg::*;

   localparam int memWords = 1 << (`MS_ADDR_W - 1);
   localparam int bankW = $clog2(`MS_BANKS);
   localparam int busyW = $clog2(`MS_BANK_BUSY + 1);

   wordT store [memWords];
   logic [busyW-1:0] busyCnt [`MS_BANKS];
   logic [bankW-1:0] bank;
   logic accept;
   logic [`MS_RD_LAT-1:0] rdValidPipe;
   wordT rdDataPipe [`MS_RD_LAT];

   // bank comes from the low word address bits
   assign bank = memAddr[bankW:1];
   assign memReady = (busyCnt[bank] == '0);
   assign accept = memValid && memReady;

   // last delay stage drives the read return
   assign memRdValid = rdValidPipe[`MS_RD_LAT-1];
   assign memRdData = rdDataPipe[`MS_RD_LAT-1];

   initial begin
      for (int i = 0; i < memWords; i++) begin
         store[i] = '0;
      end
   end

   // ########################################
   // storage and read delay line
   // ########################################
   always @(posedge clk) begin
      if (accept && memWrite) begin
         store[memAddr[`MS_ADDR_W-1:1]] <= memWrData;
      end
   end

   always_ff @(posedge clk) begin
      rdDataPipe[0] <= store[memAddr[`MS_ADDR_W-1:1]];
      for (int s = 1; s < `MS_RD_LAT; s++) begin
         rdDataPipe[s] <= rdDataPipe[s-1];
      end
   end

   // ########################################
   // bank busy counters
   // ########################################
   always_ff @(posedge clk) begin
      if (!rstN) begin
         busyCnt <= '{default: '0};
         rdValidPipe <= '0;
      end else begin
         for (int b = 0; b < `MS_BANKS; b++) begin
            if (accept && (bank == bankW'(b))) begin
               busyCnt[b] <= busyW'(`MS_BANK_BUSY);
            end else if (busyCnt[b] != '0) begin
               busyCnt[b] <= busyCnt[b] - 1'b1;
            end
         end
         // reads only, writes return nothing
         rdValidPipe[0] <= accept && !memWrite;
         for (int s = 1; s < `MS_RD_LAT; s++) begin
            rdValidPipe[s] <= rdValidPipe[s-1];
         end
      end
   end

   // controller only issues word addresses
   aMemAligned: assert property (@(posedge clk) disable iff (!rstN)
      memValid |-> !memAddr[0]);

endmodule

`default_nettype wire

// File: src/cacheController.sv
`timescale 1ns/1ps
`default_nettype none

`include "memsys_consts.svh"

module cacheController (
   input  logic               clk,
   input  logic               rstN,
   // cpu request
   input  logic               reqValid,
   output logic               reqReady,
   input  logic               reqWrite,
   input  memsysPkg::addrT    reqAddr,
   input  memsysPkg::wordT    reqData,
   // cpu response
   output logic               respValid,
   input  logic               respReady,
   output memsysPkg::wordT    respData,
   output logic               respHit,
   // lookup datapath
   input  logic               hit,
   input  logic               selDirty,
   input  memsysPkg::tagT     selTag,
   input  memsysPkg::wordT    rdData,
   output memsysPkg::indexT   lookIndex,
   output memsysPkg::offsetT  lookOffset,
   output memsysPkg::tagT     lookTag,
   output logic               wrEn,
   output memsysPkg::wordT    wrData,
   output logic               markDirty,
   output logic               fillLine,
   output logic               captureWay,
   output logic               toggleVictim,
   // memory datapath
   output logic               memValid,
   input  logic               memReady,
   output logic               memWrite,
   output memsysPkg::addrT    memAddr,
   output memsysPkg::wordT    memWrData,
   input  logic               memRdValid,
   input  memsysPkg::wordT    memRdData
);
   import memsysPkg::*;

   localparam int cntW = $clog2(`MS_LINE_WORDS) + 1;
   localparam int lastWord = `MS_LINE_WORDS - 1;

   ctrlStateT state;
   ctrlStateT nextState;
   addrT addrQ;
   wordT dataQ;
   logic writeQ;
   wordT respDataQ;
   logic respHitQ;
   logic [cntW-1:0] issueCnt;
   logic [cntW-1:0] recvCnt;
   offsetT issueOffset;
   offsetT recvOffset;
   tagT reqTag;
   indexT reqIndex;

   // fields of the latched request
   assign reqTag = addrQ[`MS_ADDR_W-1 -: `MS_TAG_W];
   assign reqIndex = addrQ[`MS_OFFSET_W +: `MS_INDEX_W];
   assign issueOffset = {issueCnt[cntW-2:0], 1'b0};
   assign recvOffset = {recvCnt[cntW-2:0], 1'b0};

   assign lookIndex = reqIndex;
   assign lookTag = reqTag;
   assign reqReady = (state == stIdle);
   assign respValid = (state == stRespond);
   assign respData = respDataQ;
   assign respHit = respHitQ;
   assign captureWay = (state == stCompare);
   assign toggleVictim = respValid && respReady;

   // evict writes the old line at its own tag, fill reads at the request tag
   assign memAddr = {(state == stEvict) ? selTag : reqTag, reqIndex, issueOffset};
   assign memWrData = rdData;
   assign wrData = (state == stFill) ? memRdData : dataQ;

   // ########################################
   // next state and datapath controls
   // ########################################
   always_comb begin
      nextState = state;
      lookOffset = addrQ[`MS_OFFSET_W-1:0];
      wrEn = 1'b0;
      markDirty = 1'b0;
      fillLine = 1'b0;
      memValid = 1'b0;
      memWrite = 1'b0;
      case (state)
         stIdle: begin
            if (reqValid) begin
               nextState = stCompare;
            end
         end
         stCompare: begin
            if (hit) begin
               wrEn = writeQ;
               markDirty = writeQ;
               nextState = stRespond;
            end else if (selDirty) begin
               nextState = stEvict;
            end else begin
               nextState = stFill;
            end
         end
         stEvict: begin
            // line word k goes out to bank k
            lookOffset = issueOffset;
            memValid = 1'b1;
            memWrite = 1'b1;
            if (memReady && (issueCnt == cntW'(lastWord))) begin
               nextState = stFill;
            end
         end
         stFill: begin
            // issue runs ahead of the returning words
            lookOffset = recvOffset;
            memValid = (issueCnt != cntW'(`MS_LINE_WORDS));
            wrEn = memRdValid;
            fillLine = 1'b1;
            if (memRdValid && (recvCnt == cntW'(lastWord))) begin
               nextState = stFinish;
            end
         end
         stFinish: begin
            // redo the access on the new line
            wrEn = writeQ;
            markDirty = writeQ;
            nextState = stRespond;
         end
         stRespond: begin
            if (respReady) begin
               nextState = stIdle;
            end
         end
         default: begin
            nextState = stIdle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         issueCnt <= '0;
         recvCnt <= '0;
      end else begin
         state <= nextState;
         if (state == stCompare) begin
            issueCnt <= '0;
            recvCnt <= '0;
         end
         // counter restarts between evict and fill
         if (memValid && memReady) begin
            if ((state == stEvict) && (issueCnt == cntW'(lastWord))) begin
               issueCnt <= '0;
            end else begin
               issueCnt <= issueCnt + 1'b1;
            end
         end
         if ((state == stFill) && memRdValid) begin
            recvCnt <= recvCnt + 1'b1;
         end
      end
   end

   // request and response payload
   always_ff @(posedge clk) begin
      if (reqValid && reqReady) begin
         addrQ <= reqAddr;
         dataQ <= reqData;
         writeQ <= reqWrite;
      end
      if (((state == stCompare) && hit) || (state == stFinish)) begin
         respDataQ <= rdData;
         respHitQ <= (state == stCompare);
      end
   end

   aReqAligned: assert property (@(posedge clk) disable iff (!rstN)
      reqValid && reqReady |-> !reqAddr[0]);

   // a held response must not change under back-pressure
   aRespStable: assert property (@(posedge clk) disable iff (!rstN)
      respValid && !respReady |=> respValid && $stable(respData) && $stable(respHit));

endmodule

`default_nettype wire

// File: src/entryArray.sv
`timescale 1ns/1ps
`default_nettype none

`include "memsys_consts.svh"

// generic storage array, one write port and one combinational read port
module entryArray #(
   parameter type entryT = memsysPkg::tagEntryT,
   parameter type idxT = memsysPkg::indexT,
   parameter int depth = `MS_SETS
) (
   input  logic  clk,
   input  logic  wrEn,
   input  idxT   wrIdx,
   input  entryT wrEntry,
   input  idxT   rdIdx,
   output entryT rdEntry
);

   // payload storage
   entryT store [depth];

   // write lands at the edge
   always_ff @(posedge clk) begin
      if (wrEn) begin
         store[wrIdx] <= wrEntry;
      end
   end

   // read is combinational, so a word written at an edge
   // is seen in the cycle right after it
   assign rdEntry = store[rdIdx];

endmodule

`default_nettype wire

// File: src/memSystem.sv
`timescale 1ns/1ps
`default_nettype none

// cache with its controller in front of the banked memory
module memSystem (
   input  logic             clk,
   input  logic             rstN,
   // cpu request
   input  logic             reqValid,
   output logic             reqReady,
   input  logic             reqWrite,
   input  memsysPkg::addrT  reqAddr,
   input  memsysPkg::wordT  reqData,
   // cpu response
   output logic             respValid,
   input  logic             respReady,
   output memsysPkg::wordT  respData,
   output logic             respHit
);
   import memsysPkg::*;

   // controller to lookup
   indexT lookIndex;
   offsetT lookOffset;
   tagT lookTag;
   logic wrEn;
   wordT wrData;
   logic markDirty;
   logic fillLine;
   logic captureWay;
   logic toggleVictim;

   // lookup to controller
   logic hit;
   logic selDirty;
   tagT selTag;
   wordT rdData;

   // controller and memory
   logic memValid;
   logic memReady;
   logic memWrite;
   addrT memAddr;
   wordT memWrData;
   logic memRdValid;
   wordT memRdData;

   // ########################################
   // blocks
   // ########################################
   cacheController uCtrl (.*);

   wayLookup uLookup (.*);

   bankedMemory uMem (.*);

endmodule

`default_nettype wire

// File: src/memsysPkg.sv
`default_nettype none

`include "memsys_consts.svh"

package memsysPkg;

   // data word and byte address
   typedef logic [`MS_DATA_W-1:0] wordT;
   typedef logic [`MS_ADDR_W-1:0] addrT;

   // address fields
   typedef logic [`MS_TAG_W-1:0] tagT;
   typedef logic [`MS_INDEX_W-1:0] indexT;
   typedef logic [`MS_OFFSET_W-1:0] offsetT;

   // tag store entry, valid lives in flops beside it
   typedef struct packed {
      logic dirty;
      tagT  tag;
   } tagEntryT;

   // way number
   typedef logic wayT;

   // controller FSM states
   typedef enum logic [2:0] {
      stIdle,
      stCompare,
      stEvict,
      stFill,
      stFinish,
      stRespond
   } ctrlStateT;

endpackage

`default_nettype wire

// File: src/memsys_consts.svh
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// word and byte address widths
`define MS_DATA_W 16
`define MS_ADDR_W 16

// address split {tag, index, byte offset}
`define MS_TAG_W 5
`define MS_INDEX_W 8
`define MS_OFFSET_W 3

// sets per way
`define MS_SETS (1 << `MS_INDEX_W)

// line and bank geometry, bank is address bits 2..1
`define MS_LINE_WORDS 4
`define MS_WAYS 2
`define MS_BANKS 4

// cycles a bank refuses new accesses after one is accepted
`define MS_BANK_BUSY 4
// cycles from an accepted read to its data
`define MS_RD_LAT 2

`endif

// File: src/wayLookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "memsys_consts.svh"

module wayLookup (
   input  logic               clk,
   input  logic               rstN,
   input  memsysPkg::indexT   lookIndex,
   input  memsysPkg::offsetT  lookOffset,
   input  memsysPkg::tagT     lookTag,
   input  logic               wrEn,
   input  memsysPkg::wordT    wrData,
   input  logic               markDirty,
   input  logic               fillLine,
   input  logic               captureWay,
   input  logic               toggleVictim,
   output logic               hit,
   output logic               selDirty,
   output memsysPkg::tagT     selTag,
   output memsysPkg::wordT    rdData
);
   import memsysPkg::*;

   // data words are addressed by {index, word number}
   typedef logic [`MS_INDEX_W+`MS_OFFSET_W-2:0] dataIdxT;

   logic [`MS_WAYS-1:0][`MS_SETS-1:0] validQ;
   logic victimQ;
   wayT selWayQ;
   wayT choice;
   wayT outWay;
   logic [`MS_WAYS-1:0] wayHit;
   logic [`MS_WAYS-1:0] wayValid;
   tagEntryT tagRd [`MS_WAYS];
   wordT dataRd [`MS_WAYS];
   dataIdxT dataIdx;

   assign dataIdx = {lookIndex, lookOffset[`MS_OFFSET_W-1:1]};

   // ########################################
   // per way storage
   // ########################################
   for (genvar w = 0; w < `MS_WAYS; w++) begin : gWay
      logic wayWr;
      logic tagWr;
      tagEntryT tagNew;

      assign wayWr = wrEn && (outWay == wayT'(w));
      // tag entry changes on a fill or when a line turns dirty
      assign tagWr = wayWr && (fillLine || markDirty);
      assign tagNew.dirty = markDirty;
      assign tagNew.tag = fillLine ? lookTag : tagRd[w].tag;

      assign wayValid[w] = validQ[w][lookIndex];
      assign wayHit[w] = wayValid[w] && (tagRd[w].tag == lookTag);

      entryArray #(.entryT(tagEntryT)) uTags (
         .clk    (clk),
         .wrEn   (tagWr),
         .wrIdx  (lookIndex),
         .wrEntry(tagNew),
         .rdIdx  (lookIndex),
         .rdEntry(tagRd[w])
      );

      entryArray #(
         .entryT(wordT),
         .idxT  (dataIdxT),
         .depth (`MS_SETS * `MS_LINE_WORDS)
      ) uData (
         .clk    (clk),
         .wrEn   (wayWr),
         .wrIdx  (dataIdx),
         .wrEntry(wrData),
         .rdIdx  (dataIdx),
         .rdEntry(dataRd[w])
      );
   end

   // ########################################
   // way choice
   // ########################################
   // hit way first, then an invalid way with way 0 first, then the victim
   always_comb begin
      if (wayHit[0]) begin
         choice = 1'b0;
      end else if (wayHit[1]) begin
         choice = 1'b1;
      end else if (!wayValid[0]) begin
         choice = 1'b0;
      end else if (!wayValid[1]) begin
         choice = 1'b1;
      end else begin
         choice = victimQ;
      end
   end

   // live choice in the compare cycle, the registered way afterwards
   assign outWay = captureWay ? choice : selWayQ;

   assign hit = |wayHit;
   assign selDirty = wayValid[outWay] && tagRd[outWay].dirty;
   assign selTag = tagRd[outWay].tag;
   assign rdData = dataRd[outWay];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validQ <= '0;
         victimQ <= 1'b0;
         selWayQ <= 1'b0;
      end else begin
         if (captureWay) begin
            selWayQ <= choice;
         end
         // one victim bit for the whole cache
         if (toggleVictim) begin
            victimQ <= ~victimQ;
         end
         if (wrEn && fillLine) begin
            validQ[outWay][lookIndex] <= 1'b1;
         end
      end
   end

   // a tag can live in only one way of a set
   aOneHit: assert property (@(posedge clk) disable iff (!rstN)
      !(wayHit[0] && wayHit[1]));

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
+incdir+bench
src/memsysPkg.sv
src/entryArray.sv
src/wayLookup.sv
src/bankedMemory.sv
src/cacheController.sv
src/memSystem.sv
bench/memSystemTb.sv
